//--- verilog/display_pkg.sv
package display_pkg;

  // Display geometry
  localparam int ROW_BITS = 512;
  localparam int ROWS     = 64;
  localparam int ADDR_W   = 6;   // log2(ROWS)

  // One scan row of pixel bits
  typedef logic [ROW_BITS-1:0] row_t;

  // Row index inside one frame
  typedef logic [ADDR_W-1:0] row_addr_t;

endpackage

//--- verilog/control_pkg.sv
package control_pkg;

  // Dwell counter width, wide enough for the slowest dwell setting
  localparam int DWELL_W = 24;

  // Frame switch control states
  typedef enum logic {
    WAITING   = 1'b0,
    SWITCHING = 1'b1
  } select_state_t;

endpackage

//--- verilog/mem_read_if.sv
`timescale 1ns/100ps

// Read port between the row reader and the frame store.
// Data is valid the cycle after rd and holds until the next read.
interface mem_read_if import display_pkg::*; ();

  logic      rd;     // Read enable
  logic      bank;   // Frame to read
  row_addr_t addr;
  row_t      data;

  modport reader (
    output rd,
    output bank,
    output addr,
    input  data
  );

  modport mem (
    input  rd,
    input  bank,
    input  addr,
    output data
  );

endinterface

//--- verilog/frame_store.sv
`timescale 1ns/100ps

module frame_store import display_pkg::*; (
  input  logic      clk,
  input  logic      wr_valid,
  input  logic      wr_frame,
  input  row_addr_t wr_addr,
  input  row_t      wr_data,
  mem_read_if.mem   rd_port
);

  // One bank per frame
  row_t bank_rows [2][ROWS];

  // Write port, always accepted
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      bank_rows[wr_frame][wr_addr] <= wr_data;
    end
  end

  // Registered read, holds between reads
  always_ff @(posedge clk) begin
    if (rd_port.rd) begin
      rd_port.data <= bank_rows[rd_port.bank][rd_port.addr];
    end
  end

endmodule

//--- verilog/dwell_timer.sv
`timescale 1ns/100ps

module dwell_timer import control_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               clear,
  input  logic               count_en,
  output logic [DWELL_W-1:0] value
);

  always_ff @(posedge clk) begin
    if (rst) begin
      value <= '0;
    end else if (clear) begin
      value <= '0;   // Clear wins over count
    end else if (count_en) begin
      value <= value + 1'b1;
    end
  end

endmodule

//--- verilog/frame_select_fsm.sv
`timescale 1ns/100ps

module frame_select_fsm import control_pkg::*; #(
  parameter int DWELL_BIT = 22
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [DWELL_W-1:0] dwell_value,
  output logic               timer_clear,
  output logic               timer_en,
  output logic               shown_frame
);

  select_state_t state;

  // Outputs are registered, so the timer reacts one cycle after the state.
  // One dwell is then 2^DWELL_BIT + 2 cycles long.
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= WAITING;
      shown_frame <= 1'b0;
      timer_clear <= 1'b1;
      timer_en    <= 1'b0;
    end else begin
      case (state)
        WAITING: begin
          if (dwell_value[DWELL_BIT]) begin
            timer_clear <= 1'b1;
            timer_en    <= 1'b0;
            shown_frame <= ~shown_frame;   // Dwell over
            state       <= SWITCHING;
          end else begin
            timer_clear <= 1'b0;
            timer_en    <= 1'b1;
          end
        end
        SWITCHING: begin
          timer_clear <= 1'b0;
          timer_en    <= 1'b1;   // Restart counting
          state       <= WAITING;
        end
        default: begin
          timer_clear <= 1'b1;
          timer_en    <= 1'b0;
          shown_frame <= 1'b0;
          state       <= WAITING;
        end
      endcase
    end
  end

endmodule

//--- verilog/row_reader.sv
`timescale 1ns/100ps

module row_reader import display_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       shown_frame,
  input  logic       req_valid,
  input  row_addr_t  req_addr,
  output logic       req_ready,
  output logic       row_valid,
  output row_t       row_data,
  output logic       row_frame,
  input  logic       row_ready,
  mem_read_if.reader mem
);

  logic       req_fire;
  logic       row_fire;

  // Read pipeline
  logic       rd_q;         // Read issued to the store this cycle
  logic       rd_bank_q;
  row_addr_t  rd_addr_q;
  logic       ret_q;        // Store data valid this cycle
  logic       ret_bank_q;

  // Two-entry output buffer
  row_t       buf_data [2];
  logic       buf_frame [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] buf_count;

  // Buffered rows plus reads in flight
  logic [1:0] occupancy;

  assign req_fire  = req_valid && req_ready;
  assign row_fire  = row_valid && row_ready;
  assign req_ready = (occupancy < 2'd2);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q  <= 1'b0;
      ret_q <= 1'b0;
    end else begin
      rd_q  <= req_fire;
      ret_q <= rd_q;
    end
  end

  // Bank is the frame shown when the request is taken
  always_ff @(posedge clk) begin
    if (req_fire) begin
      rd_addr_q <= req_addr;
      rd_bank_q <= shown_frame;
    end
    if (rd_q) begin
      ret_bank_q <= rd_bank_q;   // Follows the data out of the store
    end
  end

  assign mem.rd   = rd_q;
  assign mem.bank = rd_bank_q;
  assign mem.addr = rd_addr_q;

  always_ff @(posedge clk) begin
    if (ret_q) begin
      buf_data[wr_ptr]  <= mem.data;
      buf_frame[wr_ptr] <= ret_bank_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      buf_count <= 2'd0;
      occupancy <= 2'd0;
    end else begin
      if (ret_q) begin
        wr_ptr <= ~wr_ptr;
      end
      if (row_fire) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({ret_q, row_fire})
        2'b10:   buf_count <= buf_count + 2'd1;
        2'b01:   buf_count <= buf_count - 2'd1;
        default: buf_count <= buf_count;
      endcase
      // Counted from acceptance, so the buffer never overflows
      case ({req_fire, row_fire})
        2'b10:   occupancy <= occupancy + 2'd1;
        2'b01:   occupancy <= occupancy - 2'd1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  assign row_valid = (buf_count != 2'd0);
  assign row_data  = buf_data[rd_ptr];
  assign row_frame = buf_frame[rd_ptr];

endmodule

//--- verilog/frame_player.sv
`timescale 1ns/100ps

module frame_player import display_pkg::*, control_pkg::*; #(
  parameter int DWELL_BIT = 22
) (
  input  logic      clk,
  input  logic      rst,

  // Frame load
  input  logic      wr_valid,
  input  logic      wr_frame,
  input  row_addr_t wr_addr,
  input  row_t      wr_data,

  // Row requests from the scanner
  input  logic      req_valid,
  input  row_addr_t req_addr,
  output logic      req_ready,

  // Returned rows
  output logic      row_valid,
  output row_t      row_data,
  output logic      row_frame,
  input  logic      row_ready,

  output logic      shown_frame
);

  logic [DWELL_W-1:0] dwell_value;
  logic               timer_clear;
  logic               timer_en;

  mem_read_if rd_bus ();

  frame_select_fsm #(
    .DWELL_BIT (DWELL_BIT)
  ) u_select_fsm (
    .clk         (clk),
    .rst         (rst),
    .dwell_value (dwell_value),
    .timer_clear (timer_clear),
    .timer_en    (timer_en),
    .shown_frame (shown_frame)
  );

  dwell_timer u_dwell_timer (
    .clk      (clk),
    .rst      (rst),
    .clear    (timer_clear),
    .count_en (timer_en),
    .value    (dwell_value)
  );

  frame_store u_frame_store (
    .clk      (clk),
    .wr_valid (wr_valid),
    .wr_frame (wr_frame),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_port  (rd_bus.mem)
  );

  row_reader u_row_reader (
    .clk         (clk),
    .rst         (rst),
    .shown_frame (shown_frame),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_ready   (req_ready),
    .row_valid   (row_valid),
    .row_data    (row_data),
    .row_frame   (row_frame),
    .row_ready   (row_ready),
    .mem         (rd_bus.reader)
  );

endmodule

//--- sim/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Row r of frame f is 16 copies of one word with f in the top byte and r in the low bits
function automatic row_t row_pattern(input logic frame, input row_addr_t addr);
  row_t        row;
  logic [31:0] word;
  int          i;
  word = {7'd0, frame, 18'd0, addr};
  for (i = 0; i < ROW_BITS / 32; i++) begin
    row[i*32 +: 32] = word;
  end
  return row;
endfunction

function automatic row_t random_row();
  row_t row;
  int   i;
  for (i = 0; i < ROW_BITS / 32; i++) begin
    row[i*32 +: 32] = $urandom;
  end
  return row;
endfunction

task automatic check_value(input string name, input logic [ROW_BITS-1:0] expected,
                           input logic [ROW_BITS-1:0] actual);
  if (actual !== expected) begin
    $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    error_count++;
  end
endtask

task automatic report_error(input string msg);
  $display("ERROR: %s", msg);
  error_count++;
endtask

task automatic start_test();
  errors_at_start = error_count;
endtask

task automatic finish_test(input string name);
  if (error_count == errors_at_start) begin
    tests_passed++;
    $display("%s: ok", name);
  end else begin
    tests_failed++;
    $display("%s: %0d errors", name, error_count - errors_at_start);
  end
endtask

// Writers and readers below start and end just after a falling edge
task automatic write_row(input logic frame, input row_addr_t addr, input row_t data);
  @(posedge clk);
  wr_valid <= 1'b1;
  wr_frame <= frame;
  wr_addr  <= addr;
  wr_data  <= data;
  model_mem[frame][addr] = data;
  @(negedge clk);
endtask

task automatic stop_writes();
  @(posedge clk);
  wr_valid <= 1'b0;
  @(negedge clk);
endtask

task automatic load_frames();
  int f;
  int r;
  for (f = 0; f < 2; f++) begin
    for (r = 0; r < ROWS; r++) begin
      write_row(f[0], r[ADDR_W-1:0], row_pattern(f[0], r[ADDR_W-1:0]));
    end
  end
  stop_writes();
endtask

task automatic wait_toggle(output int at_cycle);
  logic start;
  int   n;
  start    = shown_frame;
  at_cycle = -1;
  for (n = 0; n < WAIT_LIMIT && at_cycle < 0; n++) begin
    @(negedge clk);
    if (shown_frame != start) begin
      at_cycle = cycle_count;
    end
  end
  if (at_cycle < 0) begin
    report_error("Timed out waiting for shown_frame to toggle");
  end
endtask

task automatic wait_frame(input logic frame);
  int n;
  for (n = 0; n < WAIT_LIMIT && shown_frame != frame; n++) begin
    @(negedge clk);
  end
  if (shown_frame != frame) begin
    report_error("Timed out waiting for the wanted frame to be shown");
  end
endtask

// One request, then its row
task automatic read_row(input string name, input row_addr_t addr,
                        output logic frame, output row_t data);
  int n;
  int accept_edge;
  bit done;
  frame = 1'b0;
  data  = '0;
  done  = 1'b0;
  @(posedge clk);
  req_valid <= 1'b1;
  req_addr  <= addr;
  for (n = 0; n < WAIT_LIMIT && !done; n++) begin
    @(negedge clk);
    if (req_ready) begin
      done        = 1'b1;
      frame       = shown_frame;      // Bank taken at acceptance
      accept_edge = cycle_count + 1;
    end
  end
  @(posedge clk);
  req_valid <= 1'b0;
  if (!done) begin
    report_error("Timed out waiting for req_ready");
    return;
  end
  done = 1'b0;
  for (n = 0; n < WAIT_LIMIT && !done; n++) begin
    @(negedge clk);
    done = row_valid;
  end
  if (!done) begin
    report_error("Timed out waiting for row_valid");
    return;
  end
  data = row_data;
  check_value({name, " latency of two edges or more"}, 1, (cycle_count - accept_edge) >= 2);
  check_value({name, " frame"}, frame, row_frame);
  check_value({name, " data"}, model_mem[frame][addr], row_data);
endtask

// Retries when the frame flips between the wait and the acceptance
task automatic read_in_frame(input string name, input logic frame, input row_addr_t addr,
                             output row_t data);
  logic got_frame;
  int   tries;
  got_frame = ~frame;
  for (tries = 0; tries < 4 && got_frame != frame; tries++) begin
    wait_frame(frame);
    read_row(name, addr, got_frame, data);
  end
  check_value({name, " read from wanted frame"}, frame, got_frame);
endtask

// Back-to-back requests against a reference queue
task automatic run_stream(input string name, input int count, input int stall,
                          input bit random_ready);
  logic        exp_frame [$];
  row_addr_t   exp_addr [$];
  logic        seen [2];
  logic        f;
  row_addr_t   a;
  logic [31:0] r;
  bit          fire;
  int          sent;
  int          got;
  int          held;
  int          n;
  sent    = 0;
  got     = 0;
  held    = 0;
  seen[0] = 1'b0;
  seen[1] = 1'b0;
  @(posedge clk);
  req_valid <= 1'b1;
  req_addr  <= row_addr_t'($urandom);
  row_ready <= (stall == 0);
  for (n = 0; n < WAIT_LIMIT + count * 8 && got < count; n++) begin
    @(negedge clk);
    if (sent - got >= 2) begin
      check_value({name, " req_ready with two rows outstanding"}, 0, req_ready);
    end
    if (req_valid && !req_ready) begin
      held++;
    end
    if (row_valid && row_ready) begin
      if (exp_addr.size() == 0) begin
        report_error({name, ": a row came back with no request pending"});
      end else begin
        f = exp_frame.pop_front();
        a = exp_addr.pop_front();
        seen[f] = 1'b1;
        check_value({name, " frame"}, f, row_frame);
        check_value({name, " data"}, model_mem[f][a], row_data);
        got++;
      end
    end
    fire = req_valid && req_ready;
    if (fire) begin
      exp_frame.push_back(shown_frame);
      exp_addr.push_back(req_addr);
      sent++;
    end
    @(posedge clk);
    if (sent >= count) begin
      req_valid <= 1'b0;
    end else if (fire) begin
      req_addr <= row_addr_t'($urandom);
    end
    r = $urandom;
    if (n + 1 < stall) begin
      row_ready <= 1'b0;
    end else if (random_ready) begin
      row_ready <= r[0];
    end else begin
      row_ready <= 1'b1;
    end
  end
  if (got < count) begin
    report_error($sformatf("%s: timed out with %0d of %0d rows returned", name, got, count));
  end
  @(posedge clk);
  req_valid <= 1'b0;
  row_ready <= 1'b1;
  @(negedge clk);
  check_value({name, " no extra row"}, 0, row_valid);
  check_value({name, " rows from both frames"}, 1, seen[0] && seen[1]);
  if (stall > 0) begin
    check_value({name, " req_ready fell"}, 1, held > 0);
  end
endtask

`endif

//--- sim/tb_frame_player.sv
`timescale 1ns/100ps

module tb_frame_player import display_pkg::*; ();

  localparam int DWELL_BIT    = 4;
  localparam int PERIOD       = 2 ** DWELL_BIT + 2;   // Cycles per shown frame
  localparam int RESET_CYCLES = 8;
  localparam int SEED         = 52468;
  localparam int WAIT_LIMIT   = 200;

  logic      clk;
  logic      rst;
  logic      wr_valid;
  logic      wr_frame;
  row_addr_t wr_addr;
  row_t      wr_data;
  logic      req_valid;
  row_addr_t req_addr;
  logic      req_ready;
  logic      row_valid;
  row_t      row_data;
  logic      row_frame;
  logic      row_ready;
  logic      shown_frame;

  int        cycle_count;
  int        release_cycle;
  int        error_count;
  int        errors_at_start;
  int        tests_passed;
  int        tests_failed;
  row_t      model_mem [2][ROWS];   // Expected store contents

  frame_player #(
    .DWELL_BIT (DWELL_BIT)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .wr_valid    (wr_valid),
    .wr_frame    (wr_frame),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_ready   (req_ready),
    .row_valid   (row_valid),
    .row_data    (row_data),
    .row_frame   (row_frame),
    .row_ready   (row_ready),
    .shown_frame (shown_frame)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  `include "tb_tasks.svh"

  task automatic test_reset_state();
    start_test();
    check_value("reset row_valid", 0, row_valid);
    check_value("reset req_ready", 1, req_ready);
    check_value("reset shown_frame", 0, shown_frame);
    finish_test("reset state");
  endtask

  task automatic test_frame_alternation();
    int prev;
    int now;
    int k;
    start_test();
    wait_toggle(now);
    check_value("first toggle after reset", PERIOD, now - release_cycle);
    for (k = 0; k < 4; k++) begin
      prev = now;
      wait_toggle(now);
      check_value("toggle period", PERIOD, now - prev);
    end
    finish_test("frame alternation");
  endtask

  task automatic test_single_read();
    logic frame;
    row_t data;
    start_test();
    read_row("single read", row_addr_t'($urandom), frame, data);
    finish_test("single read");
  endtask

  task automatic test_write_then_read();
    logic        frame;
    row_addr_t   addr;
    row_t        new_row;
    row_t        data;
    logic [31:0] r;
    start_test();
    r       = $urandom;
    frame   = r[0];
    addr    = row_addr_t'($urandom);
    new_row = random_row();
    write_row(frame, addr, new_row);
    stop_writes();
    read_in_frame("rewritten row", frame, addr, data);
    check_value("rewritten row new data", new_row, data);
    read_in_frame("other frame row", ~frame, addr, data);
    check_value("other frame row old data", row_pattern(~frame, addr), data);
    finish_test("write then read");
  endtask

  initial begin
    void'($urandom(SEED));
    clk          = 1'b0;
    rst          = 1'b1;
    wr_valid     = 1'b0;
    wr_frame     = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    req_valid    = 1'b0;
    req_addr     = '0;
    row_ready    = 1'b1;
    cycle_count  = 0;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    release_cycle = cycle_count;

    test_reset_state();
    test_frame_alternation();
    load_frames();
    test_single_read();
    start_test();
    run_stream("streamed reads", 32, 0, 1'b0);
    finish_test("streamed reads");
    start_test();
    run_stream("back pressure", 24, 8, 1'b1);
    finish_test("back pressure");
    test_write_then_read();

    $display("Summary: %0d tests ok, %0d tests with errors, %0d errors in total",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+sim
verilog/display_pkg.sv
verilog/control_pkg.sv
verilog/mem_read_if.sv
verilog/frame_store.sv
verilog/dwell_timer.sv
verilog/frame_select_fsm.sv
verilog/row_reader.sv
verilog/frame_player.sv
sim/tb_frame_player.sv

//--- Makefile
# Verilator build and run for the frame player testbench

VERILATOR  ?= verilator
TOP        ?= tb_frame_player
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
